// File: logic/imu_hub_pkg.sv
package imu_hub_pkg;

    // ======================================================================
    // Widths with a meaning
    // ======================================================================
    typedef logic [7:0]         byte_t;     // One SPI byte
    typedef logic signed [15:0] sample_t;   // One signed axis value
    typedef logic [15:0]        pkt_len_t;  // SHTP length, continuation bit cleared
    typedef logic [1:0]         cmd_sel_t;  // Init command index
    typedef logic [18:0]        delay_t;    // Delay counter, covers 300000 cycles

    // Link controller states
    typedef enum logic [3:0] {
        RESET_WAIT,     // Sensor settle time after reset
        WAKE,           // PS0 held low
        WAIT_INT,       // Sensor answers wake on INT
        CS_SETUP,       // cs_n low one cycle ahead of the first byte
        SEND_CMD,       // Command bytes out of the ROM
        CMD_GAP,        // Pause between commands
        WAIT_DATA,      // Initialised, idle until INT
        HDR_START,
        READ_HDR,
        READ_PAYLOAD,
        FAULT           // Wake timeout, terminal
    } link_state_t;

    // ======================================================================
    // SHTP constants
    // ======================================================================
    localparam byte_t CHAN_CONTROL = 8'd2;  // SH-2 control channel
    localparam byte_t CHAN_REPORTS = 8'd3;  // Standard input reports
    localparam byte_t CHAN_GYRO_RV = 8'd5;  // Gyro rotation vector

    localparam byte_t RID_ROT_VEC = 8'h05;
    localparam byte_t RID_GYRO    = 8'h02;  // Calibrated gyroscope

    localparam pkt_len_t SHTP_HDR_BYTES = 16'd4;
    localparam pkt_len_t MAX_PKT_LEN    = 16'd32766;

    localparam int CMD_COUNT = 3;   // Product ID, rotation vector, gyro

endpackage

// File: logic/shtp_cmd_rom.sv
`timescale 1ns/10ps

module shtp_cmd_rom (
    input  imu_hub_pkg::cmd_sel_t cmd_sel,
    input  imu_hub_pkg::byte_t    byte_idx,
    output imu_hub_pkg::byte_t    cmd_byte,
    output imu_hub_pkg::byte_t    cmd_len
);

    localparam imu_hub_pkg::byte_t PROD_ID_REQ = 8'hF9;
    localparam imu_hub_pkg::byte_t SET_FEATURE = 8'hFD;

    // Commands 1 and 2 share one body
    // Sequence number equals the command index, report ID follows it
    imu_hub_pkg::byte_t feature_rid;

    assign feature_rid = (cmd_sel == 2'd1) ? imu_hub_pkg::RID_ROT_VEC
                                           : imu_hub_pkg::RID_GYRO;

    always_comb begin
        cmd_byte = 8'h00;                           // Unlisted indices read zero
        case (cmd_sel)
            2'd0: begin                             // Product ID request
                case (byte_idx)
                    8'd0: cmd_byte = 8'h05;         // Length LSB
                    8'd2: cmd_byte = imu_hub_pkg::CHAN_CONTROL;
                    8'd4: cmd_byte = PROD_ID_REQ;
                    default: cmd_byte = 8'h00;
                endcase
            end
            2'd1, 2'd2: begin                       // Set feature command
                case (byte_idx)
                    8'd0:  cmd_byte = 8'd17;        // Length LSB
                    8'd2:  cmd_byte = imu_hub_pkg::CHAN_CONTROL;
                    8'd3:  cmd_byte = {6'd0, cmd_sel};
                    8'd4:  cmd_byte = SET_FEATURE;
                    8'd5:  cmd_byte = feature_rid;
                    8'd9:  cmd_byte = 8'h20;        // Interval 0x4E20, 50 Hz
                    8'd10: cmd_byte = 8'h4E;
                    default: cmd_byte = 8'h00;      // Flags, sensitivity, spec word
                endcase
            end
            default: cmd_byte = 8'h00;
        endcase
    end

    // Full length, header included
    always_comb begin
        case (cmd_sel)
            2'd0:       cmd_len = 8'd5;
            2'd1, 2'd2: cmd_len = 8'd17;
            default:    cmd_len = 8'd0;
        endcase
    end

endmodule

// File: logic/shtp_link_ctrl.sv
`timescale 1ns/10ps

module shtp_link_ctrl #(
    parameter int RESET_WAIT_CYCLES  = 300000,
    parameter int WAKE_HOLD_CYCLES   = 450,
    parameter int INT_TIMEOUT_CYCLES = 150000,
    parameter int CMD_GAP_CYCLES     = 30000
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  int_n,
    input  logic                  spi_busy,
    input  logic                  spi_rx_valid,
    input  imu_hub_pkg::byte_t    spi_rx_data,
    output logic                  spi_start,
    output imu_hub_pkg::byte_t    spi_tx_data,
    output logic                  cs_n,
    output logic                  ps0_wake,
    output imu_hub_pkg::cmd_sel_t cmd_sel,
    output imu_hub_pkg::byte_t    byte_idx,
    input  imu_hub_pkg::byte_t    cmd_byte,
    input  imu_hub_pkg::byte_t    cmd_len,
    output logic                  pl_valid,
    output imu_hub_pkg::byte_t    pl_byte,
    output imu_hub_pkg::byte_t    pl_idx,
    output imu_hub_pkg::byte_t    channel,
    output logic                  initialized,
    output logic                  error
);

    imu_hub_pkg::link_state_t state;
    imu_hub_pkg::delay_t      delay_cnt;
    imu_hub_pkg::delay_t      delay_limit;
    imu_hub_pkg::pkt_len_t    pkt_len;      // Header length field
    imu_hub_pkg::pkt_len_t    pl_cnt;       // Payload bytes received
    logic int_meta, int_sync;               // INT synchroniser, active low
    logic pending;                          // Byte started, rx_valid not yet seen
    logic xfer_done;
    logic len_ok;
    logic delay_done;

    assign xfer_done = pending && spi_rx_valid && !spi_busy;
    assign len_ok    = (pkt_len > imu_hub_pkg::SHTP_HDR_BYTES) &&
                       (pkt_len <= imu_hub_pkg::MAX_PKT_LEN);

    // Terminal count of the state being timed
    always_comb begin
        case (state)
            imu_hub_pkg::RESET_WAIT: delay_limit = imu_hub_pkg::delay_t'(RESET_WAIT_CYCLES - 1);
            imu_hub_pkg::WAKE:       delay_limit = imu_hub_pkg::delay_t'(WAKE_HOLD_CYCLES - 1);
            imu_hub_pkg::WAIT_INT:   delay_limit = imu_hub_pkg::delay_t'(INT_TIMEOUT_CYCLES - 1);
            imu_hub_pkg::CMD_GAP:    delay_limit = imu_hub_pkg::delay_t'(CMD_GAP_CYCLES - 1);
            default:                 delay_limit = '0;
        endcase
    end
    assign delay_done = (delay_cnt >= delay_limit);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            int_meta <= 1'b1;
            int_sync <= 1'b1;
        end else begin
            int_meta <= int_n;
            int_sync <= int_meta;
        end
    end

    // ======================================================================
    // Link FSM
    // ======================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= imu_hub_pkg::RESET_WAIT;
            delay_cnt   <= '0;
            spi_start   <= 1'b0;
            pending     <= 1'b0;
            cs_n        <= 1'b1;
            ps0_wake    <= 1'b1;   // High at reset keeps the sensor in SPI mode
            cmd_sel     <= '0;
            byte_idx    <= '0;
            pl_cnt      <= '0;
            pl_valid    <= 1'b0;
            initialized <= 1'b0;
            error       <= 1'b0;
        end else begin
            spi_start <= 1'b0;
            pl_valid  <= 1'b0;
            delay_cnt <= delay_cnt + 1'b1;  // Cleared on entry to each timed state
            case (state)
                imu_hub_pkg::RESET_WAIT: if (delay_done) begin
                    delay_cnt <= '0;
                    if (!int_sync) begin
                        state <= imu_hub_pkg::CS_SETUP;   // Sensor already asserting INT
                    end else begin
                        ps0_wake <= 1'b0;
                        state    <= imu_hub_pkg::WAKE;
                    end
                end
                imu_hub_pkg::WAKE: if (delay_done) begin
                    delay_cnt <= '0;
                    state     <= imu_hub_pkg::WAIT_INT;   // PS0 stays low meanwhile
                end
                imu_hub_pkg::WAIT_INT: begin
                    if (!int_sync) begin
                        state <= imu_hub_pkg::CS_SETUP;
                    end else if (delay_done) begin
                        error    <= 1'b1;
                        cs_n     <= 1'b1;
                        ps0_wake <= 1'b1;
                        state    <= imu_hub_pkg::FAULT;
                    end
                end
                imu_hub_pkg::CS_SETUP: begin
                    cs_n     <= 1'b0;
                    ps0_wake <= 1'b1;    // Wake released once selected
                    byte_idx <= '0;
                    state    <= imu_hub_pkg::SEND_CMD;
                end
                imu_hub_pkg::SEND_CMD: begin
                    if (xfer_done) begin
                        pending  <= 1'b0;
                        byte_idx <= byte_idx + 1'b1;
                    end else if (!pending) begin
                        if (byte_idx < cmd_len) begin
                            if (!spi_busy) begin
                                spi_start <= 1'b1;
                                pending   <= 1'b1;
                            end
                        end else begin
                            cs_n      <= 1'b1;   // Command complete
                            delay_cnt <= '0;
                            state     <= imu_hub_pkg::CMD_GAP;
                        end
                    end
                end
                imu_hub_pkg::CMD_GAP: if (delay_done) begin
                    delay_cnt <= '0;
                    if (cmd_sel < imu_hub_pkg::cmd_sel_t'(imu_hub_pkg::CMD_COUNT - 1)) begin
                        cmd_sel  <= cmd_sel + 1'b1;
                        ps0_wake <= 1'b0;        // Wake again for the next command
                        state    <= imu_hub_pkg::WAKE;
                    end else begin
                        initialized <= 1'b1;
                        state       <= imu_hub_pkg::WAIT_DATA;
                    end
                end
                imu_hub_pkg::WAIT_DATA: if (!int_sync) state <= imu_hub_pkg::HDR_START;
                imu_hub_pkg::HDR_START: begin
                    if (int_sync) begin
                        state <= imu_hub_pkg::WAIT_DATA;  // INT went away
                    end else if (!spi_busy) begin
                        cs_n      <= 1'b0;
                        byte_idx  <= '0;
                        spi_start <= 1'b1;
                        pending   <= 1'b1;
                        state     <= imu_hub_pkg::READ_HDR;
                    end
                end
                imu_hub_pkg::READ_HDR: begin
                    if (xfer_done) begin
                        pending  <= 1'b0;
                        byte_idx <= byte_idx + 1'b1;
                        if (byte_idx == 8'd3) begin
                            if (len_ok) begin
                                pl_cnt <= '0;
                                state  <= imu_hub_pkg::READ_PAYLOAD;
                            end else begin
                                cs_n  <= 1'b1;   // Empty or bad length
                                state <= imu_hub_pkg::WAIT_DATA;
                            end
                        end
                    end else if (!pending && !spi_busy) begin
                        spi_start <= 1'b1;
                        pending   <= 1'b1;
                    end
                end
                imu_hub_pkg::READ_PAYLOAD: begin
                    if (xfer_done) begin
                        pending  <= 1'b0;
                        pl_valid <= 1'b1;
                        pl_cnt   <= pl_cnt + 1'b1;
                    end else if (!pending) begin
                        if (pl_cnt < pkt_len - imu_hub_pkg::SHTP_HDR_BYTES) begin
                            if (!spi_busy) begin
                                spi_start <= 1'b1;
                                pending   <= 1'b1;
                            end
                        end else begin
                            cs_n  <= 1'b1;       // Packet end
                            state <= int_sync ? imu_hub_pkg::WAIT_DATA
                                              : imu_hub_pkg::HDR_START;
                        end
                    end
                end
                imu_hub_pkg::FAULT: error <= 1'b1;
                default: state <= imu_hub_pkg::FAULT;
            endcase
        end
    end

    // Data path, no reset
    always_ff @(posedge clk) begin
        spi_tx_data <= (state == imu_hub_pkg::SEND_CMD) ? cmd_byte : 8'h00;  // Reads send 00
        pl_byte     <= spi_rx_data;
        pl_idx      <= (pl_cnt > 16'd255) ? 8'hFF : pl_cnt[7:0];  // Saturates past parser range
        if (xfer_done && state == imu_hub_pkg::READ_HDR) begin
            case (byte_idx)
                8'd0: pkt_len[7:0]  <= spi_rx_data;                // Little-endian length
                8'd1: pkt_len[15:8] <= {1'b0, spi_rx_data[6:0]};   // Continuation bit dropped
                8'd2: channel       <= spi_rx_data;
                default: ;                                          // Sequence number unused
            endcase
        end
    end

    // Exchanger rule, a byte starts only when idle
    assert property (@(posedge clk) disable iff (!rst_n) spi_start |-> !spi_busy);
    // No clocking without chip select
    assert property (@(posedge clk) disable iff (!rst_n) spi_start |-> !cs_n);

endmodule

// File: logic/shtp_report_parser.sv
`timescale 1ns/10ps

module shtp_report_parser (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 pl_valid,
    input  imu_hub_pkg::byte_t   pl_byte,
    input  imu_hub_pkg::byte_t   pl_idx,
    input  imu_hub_pkg::byte_t   channel,
    output imu_hub_pkg::sample_t quat_w,
    output imu_hub_pkg::sample_t quat_x,
    output imu_hub_pkg::sample_t quat_y,
    output imu_hub_pkg::sample_t quat_z,
    output logic                 quat_valid,
    output imu_hub_pkg::sample_t gyro_x,
    output imu_hub_pkg::sample_t gyro_y,
    output imu_hub_pkg::sample_t gyro_z,
    output logic                 gyro_valid
);

    imu_hub_pkg::byte_t   report_id;    // Payload byte 0 of the current packet
    imu_hub_pkg::byte_t   lsb_hold;     // Low byte waiting for its pair
    imu_hub_pkg::sample_t word;
    logic accept;
    logic is_rv, is_gyro;

    // Control channel and others drop out here
    assign accept  = pl_valid && (channel == imu_hub_pkg::CHAN_REPORTS ||
                                  channel == imu_hub_pkg::CHAN_GYRO_RV);
    assign is_rv   = (report_id == imu_hub_pkg::RID_ROT_VEC);
    assign is_gyro = (report_id == imu_hub_pkg::RID_GYRO);
    assign word    = imu_hub_pkg::sample_t'({pl_byte, lsb_hold});

    // ======================================================================
    // Sample capture, MSB byte completes a word
    // ======================================================================
    always_ff @(posedge clk) begin
        if (accept) begin
            case (pl_idx)
                8'd0: report_id <= pl_byte;
                8'd4, 8'd6, 8'd8, 8'd10: lsb_hold <= pl_byte;
                8'd5: begin
                    if (is_rv) quat_x <= word;
                    else if (is_gyro) gyro_x <= word;
                end
                8'd7: begin
                    if (is_rv) quat_y <= word;
                    else if (is_gyro) gyro_y <= word;
                end
                8'd9: begin
                    if (is_rv) quat_z <= word;
                    else if (is_gyro) gyro_z <= word;
                end
                8'd11: if (is_rv) quat_w <= word;  // Real part comes last
                default: ;                          // Seq, status, delay, tail bytes
            endcase
        end
    end

    // Sticky until reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            quat_valid <= 1'b0;
            gyro_valid <= 1'b0;
        end else if (accept) begin
            if (pl_idx == 8'd11 && is_rv) quat_valid <= 1'b1;
            if (pl_idx == 8'd9 && is_gyro) gyro_valid <= 1'b1;
        end
    end

    // Strobe from the link controller must be clean
    assert property (@(posedge clk) disable iff (!rst_n) !$isunknown(pl_valid));

endmodule

// File: logic/imu_hub_top.sv
`timescale 1ns/10ps

module imu_hub_top #(
    parameter int RESET_WAIT_CYCLES  = 300000,  // About 100 ms at 3 MHz
    parameter int WAKE_HOLD_CYCLES   = 450,     // 150 us PS0 low
    parameter int INT_TIMEOUT_CYCLES = 150000,  // 50 ms wake timeout
    parameter int CMD_GAP_CYCLES     = 30000    // 10 ms between commands
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 int_n,
    input  logic                 spi_busy,
    input  logic                 spi_rx_valid,
    input  imu_hub_pkg::byte_t   spi_rx_data,
    output logic                 spi_start,
    output imu_hub_pkg::byte_t   spi_tx_data,
    output logic                 cs_n,
    output logic                 ps0_wake,
    output imu_hub_pkg::sample_t quat_w,
    output imu_hub_pkg::sample_t quat_x,
    output imu_hub_pkg::sample_t quat_y,
    output imu_hub_pkg::sample_t quat_z,
    output logic                 quat_valid,
    output imu_hub_pkg::sample_t gyro_x,
    output imu_hub_pkg::sample_t gyro_y,
    output imu_hub_pkg::sample_t gyro_z,
    output logic                 gyro_valid,
    output logic                 initialized,
    output logic                 error
);

    imu_hub_pkg::cmd_sel_t cmd_sel;
    imu_hub_pkg::byte_t    byte_idx, cmd_byte, cmd_len;
    imu_hub_pkg::byte_t    pl_byte, pl_idx, channel;
    logic                  pl_valid;

    shtp_link_ctrl #(
        .RESET_WAIT_CYCLES  (RESET_WAIT_CYCLES),
        .WAKE_HOLD_CYCLES   (WAKE_HOLD_CYCLES),
        .INT_TIMEOUT_CYCLES (INT_TIMEOUT_CYCLES),
        .CMD_GAP_CYCLES     (CMD_GAP_CYCLES)
    ) u_link (
        .clk, .rst_n, .int_n,
        .spi_busy, .spi_rx_valid, .spi_rx_data,
        .spi_start, .spi_tx_data, .cs_n, .ps0_wake,
        .cmd_sel, .byte_idx, .cmd_byte, .cmd_len,
        .pl_valid, .pl_byte, .pl_idx, .channel,
        .initialized, .error
    );

    shtp_cmd_rom u_rom (.cmd_sel, .byte_idx, .cmd_byte, .cmd_len);

    shtp_report_parser u_parser (
        .clk, .rst_n,
        .pl_valid, .pl_byte, .pl_idx, .channel,
        .quat_w, .quat_x, .quat_y, .quat_z, .quat_valid,
        .gyro_x, .gyro_y, .gyro_z, .gyro_valid
    );

endmodule

// File: verif/sensor_spi_model.sv
`timescale 1ns/10ps

module sensor_spi_model (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       spi_start,
    input  logic [7:0] spi_tx_data,
    input  logic       cs_n,
    input  logic       ps0_wake,
    input  logic [1:0] int_mode,        // 0 INT high, 1 INT low, 2 INT answers PS0
    output logic       spi_busy,
    output logic       spi_rx_valid,
    output logic [7:0] spi_rx_data,
    output logic       int_n
);

    logic [7:0] rx_q [$];               // Packet bytes still to be served
    logic [7:0] tx_log [$];             // Every byte the DUT sent
    int         frame_log [$];          // Chip-select frame of each sent byte
    int         frame = 0;
    int         busy_left = 0;
    integer     seed = 32'h131e4de5;
    logic [7:0] next_byte = 8'h00;
    logic       busy_r = 1'b0;
    logic       valid_r = 1'b0;
    logic [7:0] data_r = 8'h00;
    logic       wake_int = 1'b1;        // INT level from the wake handshake
    logic       int_r = 1'b1;
    logic       cs_d = 1'b1;

    assign spi_busy     = busy_r;
    assign spi_rx_valid = valid_r;
    assign spi_rx_data  = data_r;
    assign int_n        = int_r;

    // ======================================================================
    // Byte exchanger and sensor side of the bus
    // ======================================================================
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_r   <= 1'b0;
            valid_r  <= 1'b0;
            cs_d     <= 1'b1;
            wake_int <= (int_mode != 2'd1);
            int_r    <= (int_mode != 2'd1);   // Mode 1 holds INT low from reset on
            frame = 0;
            rx_q.delete();
            tx_log.delete();
            frame_log.delete();
        end else begin
            valid_r <= 1'b0;                  // One-cycle strobe
            cs_d    <= cs_n;
            if (cs_d && !cs_n) frame = frame + 1;
            if (spi_start) begin
                tx_log.push_back(spi_tx_data);
                frame_log.push_back(frame);
                next_byte = 8'h00;            // Empty queue reads zero
                if (rx_q.size() != 0) next_byte = rx_q.pop_front();
                busy_left = 1 + {$random(seed)} % 4;
                busy_r <= 1'b1;
            end else if (busy_r) begin
                busy_left = busy_left - 1;
                if (busy_left == 0) begin
                    busy_r  <= 1'b0;
                    valid_r <= 1'b1;
                    data_r  <= next_byte;
                end
            end
            case (int_mode)
                2'd0: wake_int <= 1'b1;
                2'd1: wake_int <= 1'b0;
                default: begin
                    if (!cs_n) wake_int <= 1'b1;          // Released once selected
                    else if (!ps0_wake) wake_int <= 1'b0;
                end
            endcase
            int_r <= (rx_q.size() != 0) ? 1'b0 : wake_int;  // Queued data holds INT low
        end
    end

    task automatic push_byte(input logic [7:0] b);
        rx_q.push_back(b);
    endtask

    function automatic int queued();
        return rx_q.size();
    endfunction

    function automatic int log_size();
        return tx_log.size();
    endfunction

    function automatic logic [7:0] log_byte(input int i);
        return tx_log[i];
    endfunction

    function automatic int log_frame(input int i);
        return frame_log[i];
    endfunction

endmodule

// File: verif/tb_imu_hub.sv
`timescale 1ns/10ps

module tb_imu_hub;

    localparam int TIMEOUT_CYCLES = 20000;  // Whole run needs about 2000 cycles

    // Rotation vector sent in the report test
    localparam logic [15:0] RV_X = 16'h1234;
    localparam logic [15:0] RV_Y = 16'hFEDC;
    localparam logic [15:0] RV_Z = 16'h8001;
    localparam logic [15:0] RV_W = 16'h7FFF;

    // Init command bytes in send order, first byte in the top lane
    localparam logic [8*5-1:0]  CMD0_BYTES = 40'h05_00_02_00_F9;
    localparam logic [8*17-1:0] CMD1_BYTES =
        136'h11_00_02_01_FD_05_00_00_00_20_4E_00_00_00_00_00_00;
    localparam logic [8*17-1:0] CMD2_BYTES =
        136'h11_00_02_02_FD_02_00_00_00_20_4E_00_00_00_00_00_00;

    logic       clk;
    logic       rst_n;
    logic [1:0] int_mode;
    logic       int_n, spi_busy, spi_rx_valid, spi_start, cs_n, ps0_wake;
    logic       quat_valid, gyro_valid, initialized, error;
    imu_hub_pkg::byte_t   spi_rx_data, spi_tx_data;
    imu_hub_pkg::sample_t quat_w, quat_x, quat_y, quat_z;
    imu_hub_pkg::sample_t gyro_x, gyro_y, gyro_z;

    int errors = 0;
    int checks = 0;
    int cycles = 0;
    int pushed = 0;                         // Bytes handed to the sensor model

    imu_hub_top #(
        .RESET_WAIT_CYCLES  (20),
        .WAKE_HOLD_CYCLES   (5),
        .INT_TIMEOUT_CYCLES (200),
        .CMD_GAP_CYCLES     (10)
    ) u_dut (
        .clk, .rst_n, .int_n,
        .spi_busy, .spi_rx_valid, .spi_rx_data,
        .spi_start, .spi_tx_data, .cs_n, .ps0_wake,
        .quat_w, .quat_x, .quat_y, .quat_z, .quat_valid,
        .gyro_x, .gyro_y, .gyro_z, .gyro_valid,
        .initialized, .error
    );

    sensor_spi_model u_model (
        .clk, .rst_n, .spi_start, .spi_tx_data, .cs_n, .ps0_wake, .int_mode,
        .spi_busy, .spi_rx_valid, .spi_rx_data, .int_n
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout, the DUT did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Closing: %0d errors in %0d checks", errors, checks);
            $display("sim failed");
            $finish;
        end
    end

    // ======================================================================
    // Helpers
    // ======================================================================
    task automatic check_value(input string name, input logic [15:0] actual,
                               input logic [15:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[ERROR] %s: got 0x%h, expected 0x%h at %0t", name, actual, expected, $time);
        end
    endtask

    task automatic apply_reset(input logic [1:0] mode);
        @(posedge clk);
        int_mode <= mode;
        rst_n    <= 1'b0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
    endtask

    task automatic wait_initialized();
        @(negedge clk);
        while (!initialized) @(negedge clk);
    endtask

    task automatic send_byte(input imu_hub_pkg::byte_t b);
        u_model.push_byte(b);
        pushed++;
    endtask

    // One SHTP report packet whose length field counts the header too
    task automatic queue_report(input imu_hub_pkg::byte_t chan, input imu_hub_pkg::byte_t rid,
                                input logic [15:0] w0, input logic [15:0] w1,
                                input logic [15:0] w2, input logic [15:0] w3,
                                input int n_words);
        logic [15:0] words [4];
        logic [15:0] len;
        words[0] = w0;
        words[1] = w1;
        words[2] = w2;
        words[3] = w3;
        len = 16'(8 + 2 * n_words);          // Header, ID, seq, status, delay, axes
        send_byte(len[7:0]);
        send_byte(len[15:8]);
        send_byte(chan);
        send_byte(8'h00);
        send_byte(rid);
        send_byte(8'h00);
        send_byte(8'h03);                    // Status byte with high accuracy
        send_byte(8'h00);
        for (int i = 0; i < n_words; i++) begin
            send_byte(words[i][7:0]);        // Little-endian pairs
            send_byte(words[i][15:8]);
        end
    endtask

    // Product ID request then two set-feature commands
    function automatic logic [7:0] expected_cmd_byte(input int cmd, input int idx);
        logic [7:0] b;
        case (cmd)
            0:       b = CMD0_BYTES[8 * (4 - idx) +: 8];
            1:       b = CMD1_BYTES[8 * (16 - idx) +: 8];
            default: b = CMD2_BYTES[8 * (16 - idx) +: 8];
        endcase
        return b;
    endfunction

    // ======================================================================
    // Directed tests
    // ======================================================================
    task automatic init_sequence();
        int idx;
        int len;
        logic wake_seen;
        apply_reset(2'd2);
        @(negedge clk);
        check_value("cs_n", cs_n, 1'b1);
        check_value("ps0_wake", ps0_wake, 1'b1);
        check_value("spi_start", spi_start, 1'b0);
        check_value("initialized", initialized, 1'b0);
        check_value("error", error, 1'b0);
        check_value("quat_valid", quat_valid, 1'b0);
        check_value("gyro_valid", gyro_valid, 1'b0);
        wait_initialized();
        check_value("tx_count", u_model.log_size(), 39);
        idx = 0;
        for (int c = 0; c < 3; c++) begin
            len = (c == 0) ? 5 : 17;
            for (int i = 0; i < len; i++) begin
                check_value("spi_tx_data", u_model.log_byte(idx), expected_cmd_byte(c, i));
                check_value("cs_frame", u_model.log_frame(idx) - u_model.log_frame(0), c);
                idx++;
            end
        end
        // Wake is skipped when INT is already low
        apply_reset(2'd1);
        wake_seen = 1'b0;
        @(negedge clk);
        while (cs_n) begin
            if (!ps0_wake) wake_seen = 1'b1;
            @(negedge clk);
        end
        check_value("ps0_wake_pulse", wake_seen, 1'b0);
    endtask

    task automatic wake_timeout();
        logic cs_seen;
        apply_reset(2'd0);
        cs_seen = 1'b0;
        @(negedge clk);
        while (!error) begin
            if (!cs_n) cs_seen = 1'b1;
            @(negedge clk);
        end
        repeat (10) @(negedge clk);
        check_value("error", error, 1'b1);
        check_value("initialized", initialized, 1'b0);
        check_value("cs_n_low_seen", cs_seen, 1'b0);
        check_value("cs_n", cs_n, 1'b1);
        check_value("ps0_wake", ps0_wake, 1'b1);
    endtask

    task automatic rotation_report();
        apply_reset(2'd2);
        wait_initialized();
        queue_report(imu_hub_pkg::CHAN_REPORTS, imu_hub_pkg::RID_ROT_VEC,
                     RV_X, RV_Y, RV_Z, RV_W, 4);
        while (!quat_valid) @(negedge clk);
        check_value("quat_x", quat_x, RV_X);
        check_value("quat_y", quat_y, RV_Y);
        check_value("quat_z", quat_z, RV_Z);
        check_value("quat_w", quat_w, RV_W);
        repeat (50) @(negedge clk);            // Flag must survive an idle stretch
        check_value("quat_valid", quat_valid, 1'b1);
        check_value("quat_w", quat_w, RV_W);
        check_value("gyro_valid", gyro_valid, 1'b0);
    endtask

    task automatic gyro_report();
        queue_report(imu_hub_pkg::CHAN_GYRO_RV, imu_hub_pkg::RID_GYRO,
                     16'h0102, 16'hFF00, 16'h4000, 16'h0000, 3);
        while (!gyro_valid) @(negedge clk);
        check_value("gyro_x", gyro_x, 16'h0102);
        check_value("gyro_y", gyro_y, 16'hFF00);
        check_value("gyro_z", gyro_z, 16'h4000);
        check_value("quat_x", quat_x, RV_X);
        check_value("quat_y", quat_y, RV_Y);
        check_value("quat_z", quat_z, RV_Z);
        check_value("quat_w", quat_w, RV_W);
    endtask

    task automatic ignored_packets();
        int base;
        base   = u_model.log_size();
        pushed = 0;
        queue_report(imu_hub_pkg::CHAN_CONTROL, imu_hub_pkg::RID_ROT_VEC,
                     16'h1111, 16'h2222, 16'h3333, 16'h4444, 4);
        send_byte(8'h04);                    // Header-only packet of length 4
        send_byte(8'h00);
        send_byte(imu_hub_pkg::CHAN_REPORTS);
        send_byte(8'h09);
        queue_report(imu_hub_pkg::CHAN_REPORTS, imu_hub_pkg::RID_GYRO,
                     16'h7654, 16'h8000, 16'h0001, 16'h0000, 3);
        while (u_model.queued() != 0) @(negedge clk);
        while (!cs_n) @(negedge clk);          // Last packet closes
        @(negedge clk);
        check_value("gyro_x", gyro_x, 16'h7654);
        check_value("gyro_y", gyro_y, 16'h8000);
        check_value("gyro_z", gyro_z, 16'h0001);
        check_value("quat_x", quat_x, RV_X);
        check_value("quat_y", quat_y, RV_Y);
        check_value("quat_z", quat_z, RV_Z);
        check_value("quat_w", quat_w, RV_W);
        check_value("read_count", u_model.log_size() - base, pushed);
        for (int i = base; i < u_model.log_size(); i++) begin
            check_value("spi_tx_data", u_model.log_byte(i), 8'h00);
        end
    endtask

    initial begin
        rst_n    = 1'b0;
        int_mode = 2'd2;
        init_sequence();
        wake_timeout();
        rotation_report();
        gyro_report();
        ignored_packets();
        repeat (5) @(negedge clk);
        $display("Closing: %0d errors in %0d checks", errors, checks);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// File: src.f
logic/imu_hub_pkg.sv
logic/shtp_cmd_rom.sv
logic/shtp_link_ctrl.sv
logic/shtp_report_parser.sv
logic/imu_hub_top.sv
verif/sensor_spi_model.sv
verif/tb_imu_hub.sv

// File: Bender.yml
package:
  name: imu_hub

sources:
  - logic/imu_hub_pkg.sv
  - logic/shtp_cmd_rom.sv
  - logic/shtp_link_ctrl.sv
  - logic/shtp_report_parser.sv
  - logic/imu_hub_top.sv
  - target: simulation
    files:
      - verif/sensor_spi_model.sv
      - verif/tb_imu_hub.sv
